/* cpu.f */
verilog/cpu_pkg.sv
verilog/cycle_ctl.sv
verilog/bus_alarm.sv
verilog/ir_decode.sv
verilog/arith_unit.sv
verilog/cpu.sv
test/bus_memory.sv
test/cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpu_tb -Mdir obj_dir -o cpu_tb_sim -f cpu.f \
	|| { echo "build failed"; exit 1; }

./obj_dir/cpu_tb_sim | tee /dev/stderr | grep -q "Result: PASSED" \
	&& echo "simulation run ok" \
	|| { echo "simulation run not ok"; exit 1; }

/* test/bus_memory.sv */
// System bus memory model
`timescale 1ns/1ps
`default_nettype none

module bus_memory (
	input wire clk_sys,
	input wire dr,
	input wire dw,
	input wire [15:0] dad,
	input wire [15:0] ddt,
	output logic rok,
	output logic [15:0] rdt
);

	localparam logic [15:0] UNMAPPED_BASE = 16'h0800;

	logic [15:0] mem [0:4095];
	integer seed = 32'h1e47f948;
	bit rand_delay = 1'b1;
	integer write_count = 0;
	logic busy = 1'b0;
	integer wait_left = 0;

	initial begin
		rok = 1'b0;
		rdt = 16'h0000;
	end

	// ----------------------------------------
	// Access from the testbench
	// ----------------------------------------

	// Fill word carries the whole address, opcode 0xA is a no-op
	task automatic clear_memory();
		for (logic [12:0] a = 13'd0; a < 13'd4096; a++)
			mem[a[11:0]] = 16'hA000 | {4'h0, a[11:0]};
	endtask

	task automatic load_word(input logic [15:0] addr, input logic [15:0] data);
		mem[addr[11:0]] = data;
	endtask

	function automatic logic [15:0] peek_word(input logic [15:0] addr);
		return mem[addr[11:0]];
	endfunction

	task automatic set_random_delay(input bit on);
		rand_delay = on;
	endtask

	function automatic integer pick_delay();
		return $unsigned($random(seed)) % 7;
	endfunction

	// ----------------------------------------
	// Bus responder
	// ----------------------------------------

	always @(negedge clk_sys) begin
		if (rok) begin
			// Acknowledge lasts exactly one cycle
			rok <= 1'b0;
		end else if (!(dr || dw)) begin
			busy = 1'b0;
		end else if (dad < UNMAPPED_BASE) begin
			if (!busy) begin
				busy = 1'b1;
				wait_left = rand_delay ? pick_delay() : 0;
			end
			if (wait_left == 0) begin
				busy = 1'b0;
				rok <= 1'b1;
				if (dr) begin
					rdt <= mem[dad[11:0]];
				end else begin
					mem[dad[11:0]] = ddt;
					write_count = write_count + 1;
				end
			end else begin
				wait_left = wait_left - 1;
			end
		end
	end

endmodule

`default_nettype wire

/* test/cpu_tb.sv */
// Accumulator processor testbench
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

	import cpu_pkg::*;

	localparam logic [7:0] ALARM_TICKS = 8'd250;
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 2000;
	localparam int RUN_LIMIT = 500;

	logic clk_sys;
	logic arst_n;
	logic start;
	logic rok;
	logic [15:0] rdt;
	logic dr;
	logic dw;
	logic [15:0] dad;
	logic [15:0] ddt;
	logic run;
	logic hlt_n;
	logic awaria;
	logic [15:0] w;
	logic [15:0] ic;

	cpu #(
		.ALARM_DLY_TICKS(ALARM_TICKS),
		.STOP_ON_NOMEM(1'b1)
	) cpu_i (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.start(start),
		.run(run),
		.hlt_n(hlt_n),
		.awaria(awaria),
		.w(w),
		.ic(ic),
		.dr(dr),
		.dw(dw),
		.dad(dad),
		.ddt(ddt),
		.rok(rok),
		.rdt(rdt)
	);

	bus_memory mem_i (
		.clk_sys(clk_sys),
		.dr(dr),
		.dw(dw),
		.dad(dad),
		.ddt(ddt),
		.rok(rok),
		.rdt(rdt)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (expected !== actual)
			fail_run($sformatf("mismatch %s expected 16'h%h actual 16'h%h",
				name, expected, actual));
	endtask

	function automatic logic [15:0] encode_instr(input logic [3:0] op, input logic [11:0] fld);
		return {op, fld};
	endfunction

	// Fill pattern of the memory model
	function automatic logic [15:0] expected_fill(input logic [15:0] addr);
		return 16'hA000 | {4'h0, addr[11:0]};
	endfunction

	task automatic apply_reset();
		@(negedge clk_sys);
		arst_n = 1'b0;
		start = 1'b0;
		repeat (3) @(negedge clk_sys);
		arst_n = 1'b1;
		@(negedge clk_sys);
		mem_i.clear_memory();
	endtask

	task automatic pulse_start();
		@(negedge clk_sys);
		start = 1'b1;
		@(negedge clk_sys);
		start = 1'b0;
	endtask

	task automatic wait_run_low(input string name, input int max_cycles);
		int n;
		n = 0;
		while (run) begin
			if (n == max_cycles)
				fail_run($sformatf("%s: run did not fall within %0d cycles", name, max_cycles));
			@(negedge clk_sys);
			n++;
		end
	endtask

	task automatic wait_for_request(input string name, input logic [15:0] addr);
		int n;
		n = 0;
		while (!(dr && dad == addr)) begin
			if (n == 100)
				fail_run($sformatf("%s: no read request to 16'h%h was seen", name, addr));
			@(negedge clk_sys);
			n++;
		end
	endtask

	// dr and dw are never high together
	always @(negedge clk_sys) begin
		if (arst_n)
			check_value("bus exclusive", 16'd0, {15'd0, dr & dw});
	end

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------

	task automatic reset_state_and_nops();
		string name;
		integer writes;
		name = "reset state";
		apply_reset();
		check_value({name, " run"}, 16'd0, {15'd0, run});
		check_value({name, " dr"}, 16'd0, {15'd0, dr});
		check_value({name, " dw"}, 16'd0, {15'd0, dw});
		check_value({name, " awaria"}, 16'd0, {15'd0, awaria});
		check_value({name, " hlt_n"}, 16'd1, {15'd0, hlt_n});
		check_value({name, " w"}, 16'h0000, w);
		check_value({name, " ic"}, 16'h0000, ic);
		// Unused codes must leave w and memory alone
		mem_i.load_word(16'h0000, encode_instr(OP_LWT, 12'h123));
		mem_i.load_word(16'h0001, encode_instr(4'h8, 12'h123));
		mem_i.load_word(16'h0002, encode_instr(4'h9, 12'hFFF));
		mem_i.load_word(16'h0003, encode_instr(4'hA, 12'h000));
		mem_i.load_word(16'h0004, encode_instr(4'hC, 12'h555));
		mem_i.load_word(16'h0005, encode_instr(4'hF, 12'h800));
		mem_i.load_word(16'h0006, encode_instr(OP_HLT, 12'h000));
		writes = mem_i.write_count;
		pulse_start();
		wait_run_low(name, RUN_LIMIT);
		check_value({name, " nop w"}, 16'h0123, w);
		check_value({name, " nop ic"}, 16'h0007, ic);
		check_value({name, " nop writes"}, 16'(writes), 16'(mem_i.write_count));
	endtask

	task automatic run_arithmetic();
		string name;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] c;
		logic [15:0] expected;
		name = "arithmetic";
		a = 16'hF123;
		b = 16'h2F00;
		c = 16'h3456;
		expected = a + b - c;
		apply_reset();
		mem_i.load_word(16'h0000, encode_instr(OP_LW, 12'h100));
		mem_i.load_word(16'h0001, encode_instr(OP_AW, 12'h101));
		mem_i.load_word(16'h0002, encode_instr(OP_SW, 12'h102));
		mem_i.load_word(16'h0003, encode_instr(OP_RW, 12'h103));
		mem_i.load_word(16'h0004, encode_instr(OP_HLT, 12'h000));
		mem_i.load_word(16'h0100, a);
		mem_i.load_word(16'h0101, b);
		mem_i.load_word(16'h0102, c);
		pulse_start();
		wait_run_low(name, RUN_LIMIT);
		check_value({name, " stored"}, expected, mem_i.peek_word(16'h0103));
		check_value({name, " w"}, expected, w);
		check_value({name, " ic"}, 16'h0005, ic);
		check_value({name, " awaria"}, 16'd0, {15'd0, awaria});
	endtask

	task automatic exercise_branches();
		string name;
		name = "branches";
		apply_reset();
		mem_i.load_word(16'h0000, encode_instr(OP_LWT, 12'h800));
		mem_i.load_word(16'h0001, encode_instr(OP_JZ, 12'h005));
		mem_i.load_word(16'h0002, encode_instr(OP_RW, 12'h110));
		mem_i.load_word(16'h0003, encode_instr(OP_LWT, 12'h000));
		mem_i.load_word(16'h0004, encode_instr(OP_JZ, 12'h007));
		mem_i.load_word(16'h0005, encode_instr(OP_RW, 12'h111));
		mem_i.load_word(16'h0006, encode_instr(OP_HLT, 12'h000));
		// Unconditional jump with a nonzero accumulator
		mem_i.load_word(16'h0007, encode_instr(OP_LWT, 12'h07F));
		mem_i.load_word(16'h0008, encode_instr(OP_UJ, 12'h00A));
		mem_i.load_word(16'h0009, encode_instr(OP_RW, 12'h112));
		mem_i.load_word(16'h000A, encode_instr(OP_RW, 12'h113));
		mem_i.load_word(16'h000B, encode_instr(OP_HLT, 12'h000));
		pulse_start();
		wait_run_low(name, RUN_LIMIT);
		// Sign extension of -2048
		check_value({name, " lwt store"}, 16'hF800, mem_i.peek_word(16'h0110));
		check_value({name, " jz skip"}, expected_fill(16'h0111), mem_i.peek_word(16'h0111));
		check_value({name, " uj skip"}, expected_fill(16'h0112), mem_i.peek_word(16'h0112));
		check_value({name, " target store"}, 16'h007F, mem_i.peek_word(16'h0113));
		check_value({name, " w"}, 16'h007F, w);
		check_value({name, " ic"}, 16'h000C, ic);
	endtask

	task automatic halt_and_resume();
		string name;
		name = "halt resume";
		apply_reset();
		mem_i.load_word(16'h0000, encode_instr(OP_LWT, 12'h005));
		mem_i.load_word(16'h0001, encode_instr(OP_HLT, 12'h000));
		mem_i.load_word(16'h0002, encode_instr(OP_AW, 12'h120));
		mem_i.load_word(16'h0003, encode_instr(OP_RW, 12'h121));
		mem_i.load_word(16'h0004, encode_instr(OP_HLT, 12'h000));
		mem_i.load_word(16'h0120, 16'h0010);
		pulse_start();
		wait_run_low(name, RUN_LIMIT);
		check_value({name, " hlt_n"}, 16'd0, {15'd0, hlt_n});
		check_value({name, " first ic"}, 16'h0002, ic);
		check_value({name, " first w"}, 16'h0005, w);
		pulse_start();
		check_value({name, " hlt_n cleared"}, 16'd1, {15'd0, hlt_n});
		wait_run_low(name, RUN_LIMIT);
		check_value({name, " stored"}, 16'h0015, mem_i.peek_word(16'h0121));
		check_value({name, " second ic"}, 16'h0005, ic);
		check_value({name, " second hlt_n"}, 16'd0, {15'd0, hlt_n});
	endtask

	task automatic load_latency_program();
		mem_i.load_word(16'h0000, encode_instr(OP_LW, 12'h130));
		mem_i.load_word(16'h0001, encode_instr(OP_AW, 12'h131));
		mem_i.load_word(16'h0002, encode_instr(OP_RW, 12'h132));
		mem_i.load_word(16'h0003, encode_instr(OP_SW, 12'h130));
		mem_i.load_word(16'h0004, encode_instr(OP_AW, 12'h132));
		mem_i.load_word(16'h0005, encode_instr(OP_RW, 12'h133));
		mem_i.load_word(16'h0006, encode_instr(OP_HLT, 12'h000));
		mem_i.load_word(16'h0130, 16'h8765);
		mem_i.load_word(16'h0131, 16'h9ABC);
	endtask

	task automatic compare_latencies();
		string name;
		logic [15:0] sum_slow;
		logic [15:0] fin_slow;
		logic [15:0] ic_slow;
		name = "latency";
		apply_reset();
		load_latency_program();
		mem_i.set_random_delay(1'b1);
		pulse_start();
		wait_run_low(name, RUN_LIMIT);
		sum_slow = mem_i.peek_word(16'h0132);
		fin_slow = mem_i.peek_word(16'h0133);
		ic_slow = ic;
		check_value({name, " random sum"}, 16'h8765 + 16'h9ABC, sum_slow);
		check_value({name, " random final"}, 16'h8765 + 16'h9ABC + 16'h9ABC, fin_slow);
		check_value({name, " random ic"}, 16'h0007, ic_slow);
		apply_reset();
		load_latency_program();
		mem_i.set_random_delay(1'b0);
		pulse_start();
		wait_run_low(name, RUN_LIMIT);
		mem_i.set_random_delay(1'b1);
		check_value({name, " zero-delay sum"}, sum_slow, mem_i.peek_word(16'h0132));
		check_value({name, " zero-delay final"}, fin_slow, mem_i.peek_word(16'h0133));
		check_value({name, " zero-delay w"}, fin_slow, w);
		check_value({name, " zero-delay ic"}, ic_slow, ic);
	endtask

	task automatic bus_alarm_stop();
		string name;
		integer writes;
		name = "bus alarm";
		apply_reset();
		mem_i.load_word(16'h0000, encode_instr(OP_LW, 12'h900));
		mem_i.load_word(16'h0001, encode_instr(OP_RW, 12'h140));
		mem_i.load_word(16'h0002, encode_instr(OP_HLT, 12'h000));
		writes = mem_i.write_count;
		pulse_start();
		wait_for_request(name, 16'h0900);
		wait_run_low(name, int'(ALARM_TICKS) + 10);
		check_value({name, " awaria"}, 16'd1, {15'd0, awaria});
		check_value({name, " hlt_n"}, 16'd1, {15'd0, hlt_n});
		check_value({name, " ic"}, 16'h0001, ic);
		repeat (20) @(negedge clk_sys);
		check_value({name, " run after"}, 16'd0, {15'd0, run});
		check_value({name, " writes"}, 16'(writes), 16'(mem_i.write_count));
		check_value({name, " no store"}, expected_fill(16'h0140), mem_i.peek_word(16'h0140));
	endtask

	// ----------------------------------------
	// Sequence and watchdog
	// ----------------------------------------

	initial begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk_sys);
		fail_run("timeout: the tests did not finish in the allowed number of cycles");
	end

	initial begin
		arst_n = 1'b0;
		start = 1'b0;
		reset_state_and_nops();
		run_arithmetic();
		exercise_branches();
		halt_and_resume();
		compare_latencies();
		bus_alarm_stop();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/arith_unit.sv */
// Accumulator, instruction counter and adder
`timescale 1ns/1ps
`default_nettype none

module arith_unit (
	input wire clk_sys,
	input wire arst_n,
	input wire cpu_pkg::dec_t dec,
	input wire [0:11] field,
	input wire cpu_pkg::word_t rdt,
	input wire rok,
	input wire ac_load_en,
	input wire ic_inc,
	input wire ic_jump,
	input wire addr_sel,
	output logic zero,
	output cpu_pkg::word_t ad,
	output cpu_pkg::word_t dt,
	output cpu_pkg::word_t w,
	output cpu_pkg::word_t ic
);

	import cpu_pkg::*;

	word_t ac;
	word_t imm;
	word_t field_addr;
	word_t operand;
	word_t result;

	// ----------------------------------------
	// Operand select
	// ----------------------------------------

	// Signed 12-bit immediate for LWT
	assign imm = {{4{field[0]}}, field};
	assign field_addr = {4'h0, field};

	// Timed-out read reads as zero
	assign operand = dec.mem_rd ? (rok ? rdt : '0) : imm;

	// Adder wraps modulo 2^16
	always_comb begin
		if (dec.ac_add)
			result = ac + operand;
		else if (dec.ac_sub)
			result = ac - operand;
		else
			result = operand;
	end

	// ----------------------------------------
	// Registers
	// ----------------------------------------

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ac <= '0;
			ic <= '0;
		end else begin
			if (ac_load_en)
				ac <= result;
			if (ic_jump)
				ic <= field_addr;
			else if (ic_inc)
				ic <= ic + 16'd1;
		end
	end

	// ----------------------------------------
	// Flags and bus drive
	// ----------------------------------------

	assign zero = (ac == '0);

	// Instruction fetch from ic, operand access from the field
	assign ad = addr_sel ? field_addr : ic;
	assign dt = ac;

	// Panel display shows the accumulator
	assign w = ac;

endmodule

`default_nettype wire

/* verilog/bus_alarm.sv */
// Bus acknowledge timeout
`timescale 1ns/1ps
`default_nettype none

module bus_alarm #(
	parameter logic [7:0] ALARM_DLY_TICKS = 8'd250
) (
	input wire clk_sys,
	input wire arst_n,
	input wire bus_busy,
	input wire rok,
	output logic alarm
);

	// Count value one cycle before the limit
	localparam logic [7:0] ALARM_LAST = ALARM_DLY_TICKS - 8'd1;

	logic [7:0] cnt;

	// Counter restarts between requests since bus_busy drops for
	// at least one cycle after each acknowledge
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= 8'd0;
			alarm <= 1'b0;
		end else if (!bus_busy || rok) begin
			cnt <= 8'd0;
			alarm <= 1'b0;
		end else begin
			// Single pulse when the count hits the limit
			alarm <= (cnt == ALARM_LAST);
			// Hold at the limit
			if (cnt != ALARM_DLY_TICKS)
				cnt <= cnt + 8'd1;
		end
	end

endmodule

`default_nettype wire

/* verilog/cpu.sv */
// Accumulator processor top level
`timescale 1ns/1ps
`default_nettype none

module cpu #(
	parameter logic [7:0] ALARM_DLY_TICKS = 8'd250,
	parameter logic STOP_ON_NOMEM = 1'b1
) (
	input wire clk_sys,
	input wire arst_n,

	// Control panel
	input wire start,
	output logic run,
	output logic hlt_n,
	output logic awaria,
	output cpu_pkg::word_t w,
	output cpu_pkg::word_t ic,

	// System bus
	output logic dr,
	output logic dw,
	output cpu_pkg::word_t dad,
	output cpu_pkg::word_t ddt,
	input wire rok,
	input wire cpu_pkg::word_t rdt
);

	import cpu_pkg::*;

	bus_req_t bus_req;
	dec_t dec;
	logic [0:11] field;
	logic bus_busy;
	logic alarm;
	logic zero;
	logic ir_load;
	logic ac_load_en;
	logic ic_inc;
	logic ic_jump;
	logic addr_sel;

	// ----------------------------------------
	// Bus ports
	// ----------------------------------------

	assign dr = bus_req.rd;
	assign dw = bus_req.wr;
	assign dad = bus_req.ad;
	assign ddt = bus_req.dt;

	// ----------------------------------------
	// Sequencer and bus timeout
	// ----------------------------------------

	cycle_ctl #(
		.STOP_ON_NOMEM(STOP_ON_NOMEM)
	) cycle_ctl_i (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.start(start),
		.rok(rok),
		.alarm(alarm),
		.dec(dec),
		.zero(zero),
		.rd(bus_req.rd),
		.wr(bus_req.wr),
		.bus_busy(bus_busy),
		.ir_load(ir_load),
		.ac_load_en(ac_load_en),
		.ic_inc(ic_inc),
		.ic_jump(ic_jump),
		.addr_sel(addr_sel),
		.run(run),
		.hlt_n(hlt_n),
		.awaria(awaria)
	);

	bus_alarm #(
		.ALARM_DLY_TICKS(ALARM_DLY_TICKS)
	) bus_alarm_i (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.bus_busy(bus_busy),
		.rok(rok),
		.alarm(alarm)
	);

	// ----------------------------------------
	// Datapath
	// ----------------------------------------

	ir_decode ir_decode_i (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.ir_load(ir_load),
		.rdt(rdt),
		.dec(dec),
		.field(field)
	);

	arith_unit arith_unit_i (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.dec(dec),
		.field(field),
		.rdt(rdt),
		.rok(rok),
		.ac_load_en(ac_load_en),
		.ic_inc(ic_inc),
		.ic_jump(ic_jump),
		.addr_sel(addr_sel),
		.zero(zero),
		.ad(bus_req.ad),
		.dt(bus_req.dt),
		.w(w),
		.ic(ic)
	);

endmodule

`default_nettype wire

/* verilog/cpu_pkg.sv */
// Accumulator processor definitions
`default_nettype none

package cpu_pkg;

	// ----------------------------------------
	// Machine word
	// ----------------------------------------

	// Bit 0 is the most significant bit
	typedef logic [0:15] word_t;

	// Opcode in bits 0..3, codes 8..15 do nothing
	typedef enum logic [3:0] {
		OP_HLT = 4'd0,
		OP_LW  = 4'd1,
		OP_RW  = 4'd2,
		OP_AW  = 4'd3,
		OP_SW  = 4'd4,
		OP_LWT = 4'd5,
		OP_UJ  = 4'd6,
		OP_JZ  = 4'd7
	} opcode_e;

	// ----------------------------------------
	// Decoded instruction
	// ----------------------------------------

	typedef struct packed {
		logic mem_rd;
		logic mem_wr;
		logic ac_load;
		logic ac_add;
		logic ac_sub;
		logic jump;
		logic jump_zero;
		logic halt;
	} dec_t;

	// One system bus request
	typedef struct packed {
		logic rd;
		logic wr;
		word_t ad;
		word_t dt;
	} bus_req_t;

endpackage

`default_nettype wire

/* verilog/cycle_ctl.sv */
// Instruction cycle sequencer
`timescale 1ns/1ps
`default_nettype none

module cycle_ctl #(
	parameter logic STOP_ON_NOMEM = 1'b1
) (
	input wire clk_sys,
	input wire arst_n,
	input wire start,
	input wire rok,
	input wire alarm,
	input wire cpu_pkg::dec_t dec,
	input wire zero,
	output logic rd,
	output logic wr,
	output logic bus_busy,
	output logic ir_load,
	output logic ac_load_en,
	output logic ic_inc,
	output logic ic_jump,
	output logic addr_sel,
	output logic run,
	output logic hlt_n,
	output logic awaria
);

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		DECODE,
		OPER,
		EXEC
	} state_e;

	state_e state;
	state_e state_nx;
	logic hlt_q;
	logic awaria_q;
	logic fetch_lost;
	logic mem_op;
	logic bus_fail;
	logic bus_end;
	logic exec_act;

	assign mem_op = dec.mem_rd | dec.mem_wr;

	// Request timed out with no acknowledge
	assign bus_fail = bus_busy & alarm & ~rok;
	// Without stop on missing memory the timeout ends the phase, data taken as 0
	assign bus_end = rok | (bus_fail & ~STOP_ON_NOMEM);

	// A fetch that got no answer executes as a no-op
	assign exec_act = (state == EXEC) & ~fetch_lost;

	// ----------------------------------------
	// Bus and datapath strobes
	// ----------------------------------------

	assign rd = (state == FETCH) | ((state == OPER) & dec.mem_rd);
	assign wr = (state == OPER) & dec.mem_wr;
	assign bus_busy = rd | wr;

	assign ir_load = (state == FETCH) & rok;
	assign ic_inc = (state == FETCH) & bus_end;
	assign addr_sel = (state == OPER);

	// Memory operand lands with rok, immediate in EXEC
	assign ac_load_en = ((state == OPER) & dec.mem_rd & bus_end)
		| (exec_act & ~dec.mem_rd & (dec.ac_load | dec.ac_add | dec.ac_sub));
	assign ic_jump = exec_act & (dec.jump | (dec.jump_zero & zero));

	assign run = (state != IDLE);
	assign hlt_n = ~hlt_q;
	assign awaria = awaria_q;

	// ----------------------------------------
	// State machine
	// ----------------------------------------

	always_comb begin
		state_nx = state;
		case (state)
			IDLE: begin
				if (start)
					state_nx = FETCH;
			end
			FETCH: begin
				if (rok)
					state_nx = DECODE;
				else if (bus_end)
					state_nx = EXEC;
				else if (bus_fail)
					state_nx = IDLE;
			end
			DECODE: begin
				state_nx = mem_op ? OPER : EXEC;
			end
			OPER: begin
				if (bus_end)
					state_nx = EXEC;
				else if (bus_fail)
					state_nx = IDLE;
			end
			EXEC: begin
				state_nx = (dec.halt & ~fetch_lost) ? IDLE : FETCH;
			end
			default: begin
				state_nx = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			fetch_lost <= 1'b0;
			hlt_q <= 1'b0;
			awaria_q <= 1'b0;
		end else begin
			state <= state_nx;
			fetch_lost <= (state == FETCH) & ~rok & bus_end;
			// Halt indication lasts until the next start
			if ((state == IDLE) & start)
				hlt_q <= 1'b0;
			else if (exec_act & dec.halt)
				hlt_q <= 1'b1;
			if (bus_fail)
				awaria_q <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/ir_decode.sv */
// Instruction register and decoder
`timescale 1ns/1ps
`default_nettype none

module ir_decode (
	input wire clk_sys,
	input wire arst_n,
	input wire ir_load,
	input wire cpu_pkg::word_t rdt,
	output cpu_pkg::dec_t dec,
	output logic [0:11] field
);

	import cpu_pkg::*;

	word_t ir;
	opcode_e op;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			ir <= '0;
		else if (ir_load)
			ir <= rdt;
	end

	// Opcode in bits 0..3, address or immediate in 4..15
	assign op = opcode_e'(ir[0:3]);
	assign field = ir[4:15];

	always_comb begin
		dec = '0;
		case (op)
			OP_HLT: begin
				dec.halt = 1'b1;
			end
			OP_LW: begin
				dec.mem_rd = 1'b1;
				dec.ac_load = 1'b1;
			end
			OP_RW: begin
				dec.mem_wr = 1'b1;
			end
			OP_AW: begin
				dec.mem_rd = 1'b1;
				dec.ac_add = 1'b1;
			end
			OP_SW: begin
				dec.mem_rd = 1'b1;
				dec.ac_sub = 1'b1;
			end
			OP_LWT: begin
				dec.ac_load = 1'b1;
			end
			OP_UJ: begin
				dec.jump = 1'b1;
			end
			OP_JZ: begin
				dec.jump_zero = 1'b1;
			end
			// Codes 8..15 leave every field clear
			default: begin
				dec = '0;
			end
		endcase
	end

endmodule

`default_nettype wire
